/* hdl/drive_pkg.sv */
package drive_pkg;

    // signed wheel speed, negative runs the wheel backward.
    typedef logic signed [9:0] speed_t;

    // debounced floor pattern, left sensor in bit 2.
    typedef logic [2:0] mode_t;

    // duty magnitude on a 1024 scale.
    typedef logic [9:0] duty_t;

    // speed limits.
    localparam speed_t FULL_SPEED = 10'sd511;
    localparam speed_t MIN_SPEED  = -10'sd300;

    // steering steps, applied once per period.
    localparam speed_t SPEED_STEP = 10'sd50;
    localparam speed_t LOW_BRAKE  = 10'sd100;
    localparam speed_t HIGH_BRAKE = 10'sd200;

    // period counter and compare threshold width.
    localparam int CNT_W = 12;

    // sensor patterns with a named steering action.
    localparam mode_t MODE_STRAIGHT   = 3'b111;
    localparam mode_t MODE_SOFT_LEFT  = 3'b110;
    localparam mode_t MODE_HARD_LEFT  = 3'b100;
    localparam mode_t MODE_SOFT_RIGHT = 3'b011;
    localparam mode_t MODE_HARD_RIGHT = 3'b001;
    localparam mode_t MODE_LOST       = 3'b000;

endpackage

/* hdl/duty_scaler.sv */
`timescale 1ns/1ns

module duty_scaler #(
    parameter int PERIOD_CYCLES = 4000
) (
    input  logic      clk,
    input  logic      rst,
    wheel_cmd_if.sink wheel,
    pwm_cmd_if.source pwm_cmd
);
    import drive_pkg::*;

    // magnitude with a leading one, low bits flipped when backward.
    function automatic duty_t to_duty(speed_t s);
        return {1'b1, s[9] ? ~s[8:0] : s[8:0]};
    endfunction

    // period cycles times duty over 1024, rounded down.
    function automatic logic [CNT_W-1:0] to_threshold(speed_t s);
        logic [31:0] prod;
        prod = PERIOD_CYCLES * 32'(to_duty(s));
        return prod[CNT_W+9:10];
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pwm_cmd.valid <= 1'b0;
        end else begin
            pwm_cmd.valid <= wheel.valid;
        end
    end

    // payload follows valid, no reset.
    always_ff @(posedge clk) begin
        if (wheel.valid) begin
            pwm_cmd.left_threshold  <= to_threshold(wheel.left_speed);
            pwm_cmd.right_threshold <= to_threshold(wheel.right_speed);
            pwm_cmd.dir             <= {wheel.left_speed[9], wheel.right_speed[9]};
        end
    end

    // no storage here, so the slot credit goes straight upstream.
    assign wheel.credit = pwm_cmd.credit;

endmodule

/* hdl/line_follower_drive.sv */
`timescale 1ns/1ns

module line_follower_drive #(
    parameter int PERIOD_CYCLES   = 4000,
    parameter int DEBOUNCE_CYCLES = 16
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [2:0] sensors,
    output logic [1:0] pwm,   // left wheel in bit 1.
    output logic [1:0] dir    // 1 runs the wheel backward.
);
    import drive_pkg::*;

    mode_t mode;

    wheel_cmd_if wheel_bus ();
    pwm_cmd_if   pwm_bus ();

    sensor_filter #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) sensor_filter0 (
        .clk     (clk),
        .rst     (rst),
        .sensors (sensors),
        .mode    (mode)
    );

    speed_ramp speed_ramp0 (
        .clk  (clk),
        .rst  (rst),
        .mode (mode),
        .cmd  (wheel_bus.source)
    );

    duty_scaler #(
        .PERIOD_CYCLES (PERIOD_CYCLES)
    ) duty_scaler0 (
        .clk     (clk),
        .rst     (rst),
        .wheel   (wheel_bus.sink),
        .pwm_cmd (pwm_bus.source)
    );

    pwm_generator #(
        .PERIOD_CYCLES (PERIOD_CYCLES)
    ) pwm_generator0 (
        .clk (clk),
        .rst (rst),
        .cmd (pwm_bus.sink),
        .pwm (pwm),
        .dir (dir)
    );

endmodule

/* hdl/pwm_cmd_if.sv */
`timescale 1ns/1ns

interface pwm_cmd_if;
    import drive_pkg::*;

    logic             valid;
    logic [CNT_W-1:0] left_threshold;
    logic [CNT_W-1:0] right_threshold;
    logic [1:0]       dir;    // left wheel in bit 1.

    // pulses when the command slot is taken at a wrap.
    logic             credit;

    modport source (
        output valid, left_threshold, right_threshold, dir,
        input  credit
    );

    modport sink (
        input  valid, left_threshold, right_threshold, dir,
        output credit
    );

endinterface

/* hdl/pwm_generator.sv */
`timescale 1ns/1ns

module pwm_generator #(
    parameter int PERIOD_CYCLES = 4000
) (
    input  logic      clk,
    input  logic      rst,
    pwm_cmd_if.sink   cmd,
    output logic [1:0] pwm,
    output logic [1:0] dir
);
    import drive_pkg::*;

    logic [CNT_W-1:0] cnt;
    logic             wrap;

    logic             slot_full;
    logic [CNT_W-1:0] slot_left;
    logic [CNT_W-1:0] slot_right;
    logic [1:0]       slot_dir;

    logic [CNT_W-1:0] act_left;
    logic [CNT_W-1:0] act_right;
    logic [1:0]       act_dir;

    assign wrap = (cnt == CNT_W'(PERIOD_CYCLES - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else begin
            cnt <= wrap ? '0 : cnt + 1'b1;
        end
    end

    // one-deep slot.
    always_ff @(posedge clk) begin
        if (cmd.valid) begin
            slot_left  <= cmd.left_threshold;
            slot_right <= cmd.right_threshold;
            slot_dir   <= cmd.dir;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slot_full  <= 1'b0;
            cmd.credit <= 1'b0;
            act_left   <= '0;  // first period stays low.
            act_right  <= '0;
            act_dir    <= 2'b00;
        end else begin
            cmd.credit <= wrap && slot_full;
            if (cmd.valid) begin
                slot_full <= 1'b1;
            end else if (wrap && slot_full) begin
                slot_full <= 1'b0;
            end
            if (wrap && slot_full) begin
                act_left  <= slot_left;
                act_right <= slot_right;
                act_dir   <= slot_dir;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pwm <= 2'b00;
            dir <= 2'b00;
        end else begin
            pwm <= {cnt < act_left, cnt < act_right};
            dir <= act_dir;
        end
    end

    // upstream must wait for the credit from the last wrap.
    a_no_overrun: assert property (@(posedge clk) disable iff (rst)
        cmd.valid |-> !slot_full)
        else $error("command arrived with slot full");

    a_cnt_range: assert property (@(posedge clk) disable iff (rst)
        cnt < CNT_W'(PERIOD_CYCLES))
        else $error("period counter out of range");

endmodule

/* hdl/sensor_filter.sv */
`timescale 1ns/1ns

module sensor_filter #(
    parameter int DEBOUNCE_CYCLES = 16
) (
    input  logic               clk,
    input  logic               rst,
    input  logic [2:0]         sensors,
    output drive_pkg::mode_t   mode
);
    import drive_pkg::*;

    localparam int CNT_BITS = $clog2(DEBOUNCE_CYCLES) + 1;

    mode_t               sync_q0;
    mode_t               sync_q1;
    mode_t               cand;      // pattern waiting to be accepted.
    logic [CNT_BITS-1:0] stable_cnt;

    // two-flop synchronizer.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sync_q0 <= MODE_STRAIGHT;
            sync_q1 <= MODE_STRAIGHT;
        end else begin
            sync_q0 <= sensors;
            sync_q1 <= sync_q0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cand       <= MODE_STRAIGHT;
            stable_cnt <= '0;
            mode       <= MODE_STRAIGHT;
        end else if (sync_q1 != cand) begin
            cand       <= sync_q1;  // restart the window.
            stable_cnt <= CNT_BITS'(1);
        end else if (cand != mode) begin
            if (stable_cnt == CNT_BITS'(DEBOUNCE_CYCLES - 1)) begin
                mode       <= cand;
                stable_cnt <= '0;
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end else begin
            stable_cnt <= '0;
        end
    end

endmodule

/* hdl/speed_ramp.sv */
`timescale 1ns/1ns

module speed_ramp (
    input  logic             clk,
    input  logic             rst,
    input  drive_pkg::mode_t mode,
    wheel_cmd_if.source      cmd
);
    import drive_pkg::*;

    speed_t     left_q;
    speed_t     right_q;
    speed_t     left_next;
    speed_t     right_next;
    logic [1:0] credit_cnt;
    logic       send;

    // speed up by one step, saturating at full speed.
    function automatic speed_t step_up(speed_t s);
        logic signed [10:0] sum;
        sum = s + SPEED_STEP;
        return (sum > FULL_SPEED) ? FULL_SPEED : sum[9:0];
    endfunction

    // slow down by amount, never below floor.
    function automatic speed_t step_down(speed_t s, speed_t amount, speed_t floor);
        logic signed [10:0] diff;
        diff = s - amount;
        return (diff < floor) ? floor : diff[9:0];
    endfunction

    always_comb begin
        case (mode)
            MODE_STRAIGHT: begin
                left_next  = step_up(left_q);
                right_next = step_up(right_q);
            end
            MODE_SOFT_LEFT: begin
                left_next  = step_down(left_q, LOW_BRAKE, 10'sd0);
                right_next = step_up(right_q);
            end
            MODE_HARD_LEFT: begin
                left_next  = step_down(left_q, HIGH_BRAKE, MIN_SPEED);
                right_next = step_up(right_q);
            end
            MODE_SOFT_RIGHT: begin
                left_next  = step_up(left_q);
                right_next = step_down(right_q, LOW_BRAKE, 10'sd0);
            end
            MODE_HARD_RIGHT: begin
                left_next  = step_up(left_q);
                right_next = step_down(right_q, HIGH_BRAKE, MIN_SPEED);
            end
            MODE_LOST: begin
                // spin in place toward the faster wheel.
                left_next  = (left_q > right_q) ? FULL_SPEED : MIN_SPEED;
                right_next = (left_q > right_q) ? MIN_SPEED : FULL_SPEED;
            end
            default: begin
                left_next  = MIN_SPEED;
                right_next = MIN_SPEED;
            end
        endcase
    end

    assign send = (credit_cnt != 2'd0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            left_q     <= FULL_SPEED;
            right_q    <= FULL_SPEED;
            credit_cnt <= 2'd1;     // the pwm slot starts empty.
            cmd.valid  <= 1'b0;
        end else begin
            cmd.valid  <= send;
            credit_cnt <= credit_cnt - {1'b0, send} + {1'b0, cmd.credit};
            if (send) begin
                left_q  <= left_next;
                right_q <= right_next;
            end
        end
    end

    assign cmd.left_speed  = left_q;
    assign cmd.right_speed = right_q;

    a_speed_range: assert property (@(posedge clk) disable iff (rst)
        left_q >= MIN_SPEED && left_q <= FULL_SPEED &&
        right_q >= MIN_SPEED && right_q <= FULL_SPEED)
        else $error("speed out of range");

    // the next command waits for a credit from downstream.
    a_valid_credit: assert property (@(posedge clk) disable iff (rst)
        cmd.valid |=> !cmd.valid throughout cmd.credit[->1])
        else $error("valid sent without credit");

    a_credit_max: assert property (@(posedge clk) disable iff (rst)
        credit_cnt <= 2'd1)
        else $error("credit count above one");

endmodule

/* hdl/wheel_cmd_if.sv */
`timescale 1ns/1ns

interface wheel_cmd_if;
    import drive_pkg::*;

    logic   valid;       // one-cycle pulse per command.
    speed_t left_speed;
    speed_t right_speed;
    logic   credit;      // slot freed downstream.

    modport source (
        output valid, left_speed, right_speed,
        input  credit
    );

    modport sink (
        input  valid, left_speed, right_speed,
        output credit
    );

endinterface

/* line_follower_drive.f */
hdl/drive_pkg.sv
hdl/wheel_cmd_if.sv
hdl/pwm_cmd_if.sv
hdl/sensor_filter.sv
hdl/speed_ramp.sv
hdl/duty_scaler.sv
hdl/pwm_generator.sv
hdl/line_follower_drive.sv
testbench/tb_line_follower_drive.sv

/* testbench/tb_line_follower_drive.sv */
`timescale 1ns/1ns

module tb_line_follower_drive;
    import drive_pkg::*;

    localparam int PERIOD_CYCLES   = 100;
    localparam int DEBOUNCE_CYCLES = 4;
    localparam int HOLD            = 20;  // enough periods for the longest ramp.
    localparam int SHORT           = 4;
    localparam int CHECK           = 3;
    localparam int GLITCH_PERIODS  = 10;
    localparam int RUN_PERIODS     = 9 * (HOLD + CHECK) + 2 * (SHORT + CHECK)
                                     + GLITCH_PERIODS + 2;
    localparam int TIMEOUT_CYCLES  = (RUN_PERIODS + 20) * PERIOD_CYCLES;

    logic       clk;
    logic       rst;
    logic [2:0] sensors;
    logic [1:0] pwm;
    logic [1:0] dir;

    logic [1:0] pwm_q;
    logic       seen_rise;
    logic       meas_done;   // one cycle after a full period was measured.
    int         cyc;
    int         period_count;
    int         left_cnt;
    int         right_cnt;
    int         len_cnt;
    logic [1:0] win_dir;
    int         meas_left;
    int         meas_right;
    int         meas_len;
    logic [1:0] meas_dir;
    int         prev_left;
    logic       prev_back;

    logic       exp_on;
    logic       mono_on;
    int         exp_left;
    int         exp_right;
    logic [1:0] exp_dir;

    line_follower_drive #(
        .PERIOD_CYCLES   (PERIOD_CYCLES),
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) dut0 (
        .clk     (clk),
        .rst     (rst),
        .sensors (sensors),
        .pwm     (pwm),
        .dir     (dir)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // high cycles per period for a signed speed.
    function automatic int high_cycles(int speed);
        int duty;
        duty = (speed >= 0) ? 512 + speed : 511 - speed;  // backward folds around 512.
        return (PERIOD_CYCLES * duty) / 1024;
    endfunction

    // backward periods count as negative.
    function automatic int signed_level(int high, logic backward);
        return backward ? -high : high;
    endfunction

    task automatic report_value(string name, int got, int expected);
        $display("error %s: got 0x%0h, expected 0x%0h", name, got, expected);
        $display("TEST FAILED");
        $fatal(1, "mismatch on %s", name);
    endtask

    task automatic report_text(string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "%s", msg);
    endtask

    // one window runs from one rising edge of the left pwm to the next.
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            pwm_q        <= 2'b00;
            seen_rise    <= 1'b0;
            meas_done    <= 1'b0;
            cyc          <= 0;
            period_count <= 0;
            left_cnt     <= 0;
            right_cnt    <= 0;
            len_cnt      <= 0;
            win_dir      <= 2'b00;
            meas_left    <= 0;
            meas_right   <= 0;
            meas_len     <= 0;
            meas_dir     <= 2'b00;
            prev_left    <= 0;
            prev_back    <= 1'b0;
        end else begin
            cyc       <= cyc + 1;
            pwm_q     <= pwm;
            meas_done <= 1'b0;
            if (pwm[1] && !pwm_q[1]) begin
                if (seen_rise) begin
                    prev_left    <= meas_left;
                    prev_back    <= meas_dir[1];
                    meas_left    <= left_cnt;
                    meas_right   <= right_cnt;
                    meas_len     <= len_cnt;
                    meas_dir     <= win_dir;
                    meas_done    <= 1'b1;
                    period_count <= period_count + 1;
                end
                seen_rise <= 1'b1;
                left_cnt  <= 1;
                right_cnt <= pwm[0] ? 1 : 0;
                len_cnt   <= 1;
                win_dir   <= dir;
            end else begin
                left_cnt  <= left_cnt + (pwm[1] ? 1 : 0);
                right_cnt <= right_cnt + (pwm[0] ? 1 : 0);
                len_cnt   <= len_cnt + 1;
            end
        end
    end

    // first period after reset is all low.
    a_pwm_quiet: assert property (@(posedge clk) disable iff (rst)
        cyc < PERIOD_CYCLES |-> pwm == 2'b00)
        else report_value("pwm", $sampled(pwm), 0);

    a_dir_quiet: assert property (@(posedge clk) disable iff (rst)
        cyc < PERIOD_CYCLES |-> dir == 2'b00)
        else report_value("dir", $sampled(dir), 0);

    a_period_len: assert property (@(posedge clk) disable iff (rst)
        meas_done |-> meas_len == PERIOD_CYCLES)
        else report_value("pwm period", $sampled(meas_len), PERIOD_CYCLES);

    a_left_high: assert property (@(posedge clk) disable iff (rst)
        meas_done && exp_on |-> meas_left == exp_left)
        else report_value("pwm[1] high cycles", $sampled(meas_left), $sampled(exp_left));

    a_right_high: assert property (@(posedge clk) disable iff (rst)
        meas_done && exp_on |-> meas_right == exp_right)
        else report_value("pwm[0] high cycles", $sampled(meas_right), $sampled(exp_right));

    a_dir_value: assert property (@(posedge clk) disable iff (rst)
        meas_done && exp_on |-> meas_dir == exp_dir)
        else report_value("dir", $sampled(meas_dir), $sampled(exp_dir));

    a_left_rising: assert property (@(posedge clk) disable iff (rst)
        meas_done && mono_on |->
            signed_level(meas_left, meas_dir[1]) >= signed_level(prev_left, prev_back))
        else report_text("left wheel slowed down between two periods while speeding up");

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

    task automatic wait_periods(int n);
        int target;
        target = period_count + n;
        while (period_count < target) begin
            @(negedge clk);
        end
    endtask

    task automatic set_expected(int left_speed, int right_speed);
        exp_left  = high_cycles(left_speed);
        exp_right = high_cycles(right_speed);
        exp_dir   = {left_speed < 0, right_speed < 0};
    endtask

    // hold a pattern, then check the settled speeds.
    task automatic hold_pattern(logic [2:0] pattern, int settle, int left_speed,
                                int right_speed);
        sensors = pattern;
        exp_on  = 1'b0;
        wait_periods(settle);
        set_expected(left_speed, right_speed);
        exp_on = 1'b1;
        wait_periods(CHECK);
        exp_on = 1'b0;
    endtask

    task automatic inject_glitches(int periods);
        int         target;
        int         gap;
        int         len;
        logic [2:0] pat;
        target = period_count + periods;
        while (period_count < target) begin
            gap = $urandom_range(40, 10);
            len = $urandom_range(2, 1);
            pat = 3'($urandom_range(6, 0));  // never 111.
            repeat (gap) @(negedge clk);
            sensors = pat;
            repeat (len) @(negedge clk);
            sensors = MODE_STRAIGHT;
        end
    endtask

    initial begin
        void'($urandom(20));
        rst       = 1'b1;
        sensors   = MODE_STRAIGHT;
        exp_on    = 1'b0;
        mono_on   = 1'b0;
        exp_left  = 0;
        exp_right = 0;
        exp_dir   = 2'b00;
        repeat (4) @(negedge clk);
        rst = 1'b0;

        hold_pattern(MODE_STRAIGHT, HOLD, FULL_SPEED, FULL_SPEED);
        hold_pattern(3'b010, HOLD, MIN_SPEED, MIN_SPEED);
        hold_pattern(3'b101, HOLD, MIN_SPEED, MIN_SPEED);
        hold_pattern(MODE_SOFT_LEFT, HOLD, 0, FULL_SPEED);
        hold_pattern(MODE_LOST, SHORT, MIN_SPEED, FULL_SPEED);  // left was slower.
        hold_pattern(MODE_HARD_LEFT, HOLD, MIN_SPEED, FULL_SPEED);
        mono_on = 1'b1;
        hold_pattern(MODE_STRAIGHT, HOLD, FULL_SPEED, FULL_SPEED);
        mono_on = 1'b0;
        hold_pattern(MODE_SOFT_RIGHT, HOLD, FULL_SPEED, 0);
        hold_pattern(MODE_LOST, SHORT, FULL_SPEED, MIN_SPEED);
        hold_pattern(MODE_HARD_RIGHT, HOLD, FULL_SPEED, MIN_SPEED);
        hold_pattern(MODE_STRAIGHT, HOLD, FULL_SPEED, FULL_SPEED);

        // short glitches must not reach the wheels.
        set_expected(FULL_SPEED, FULL_SPEED);
        exp_on = 1'b1;
        inject_glitches(GLITCH_PERIODS);
        exp_on = 1'b0;

        repeat (2) @(negedge clk);
        $display("TEST PASSED");
        $finish;
    end

endmodule
